// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // system size
  localparam int CORES = 2;
  localparam int RAM_WORDS = 256;
  // busy cycles before the access cycle
  localparam int RAM_LAT = 2;
  // ram row index width, row sits just above the byte offset
  localparam int ROW_W = $clog2(RAM_WORDS);
  localparam int LAT_W = $clog2(RAM_LAT + 1);

  typedef logic [31:0] word_t;
  // byte address, bits ROW_W+1:2 pick the ram row
  typedef logic [31:0] addr_t;
  typedef logic [$clog2(CORES)-1:0] core_id_t;
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [LAT_W-1:0] lat_cnt_t;

  typedef enum logic [1:0] {FREE, BUSY, ACCESS} ram_state_t;

  // controller states, X variants take the line exclusive
  typedef enum logic [3:0] {
    IDLE, IMEM, CACWB, PRRD, PRWR,
    BUSRD1, BUSRD2, BUSWB1, BUSWB2,
    BUSRDX1, BUSRDX2, BUSWBX1, BUSWBX2
  } mc_state_t;

  // data path currently set up by the controller
  typedef enum logic [2:0] {
    R_NONE, R_RAM_I, R_RAM_D, R_PEER_D_RAM, R_PEER_D, R_D_RAM
  } route_t;

  // one cache toward the bus
  typedef struct packed {
    logic  iren;
    logic  dren;
    logic  dwen;
    logic  ccwrite;
    addr_t iaddr;
    addr_t daddr;
    word_t dstore;
  } cache_req_t;

  // bus back toward one cache
  typedef struct packed {
    logic  iwait;
    logic  dwait;
    word_t iload;
    word_t dload;
    logic  ccwait;
    logic  ccinv;
    addr_t ccsnoopaddr;
  } cache_rsp_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    addr_t addr;
    word_t store;
  } ram_req_t;

  typedef struct packed {
    word_t      load;
    ram_state_t state;
  } ram_rsp_t;

  // controller to router
  typedef struct packed {
    route_t route;
    // owner's current word finishes this cycle
    logic   word_done;
    // one cycle pulse to the peer
    logic   invalidate;
    // peer is being snooped or is sourcing data
    logic   snoop;
  } bus_ctrl_t;

  // any request level raised by a cache
  function automatic logic req_any(cache_req_t r);
    return r.iren | r.dren | r.dwen | r.ccwrite;
  endfunction

endpackage

// ==== rtl/core_arbiter.sv ====
`timescale 1ns/100ps

module core_arbiter (
  input  logic                                            CLK,
  input  logic                                            nRST,
  input  mem_bus_pkg::cache_req_t [mem_bus_pkg::CORES-1:0] req,
  input  logic                                            switch_ok,
  output mem_bus_pkg::core_id_t                           owner
);

  mem_bus_pkg::core_id_t other;
  mem_bus_pkg::core_id_t next_owner;
  logic own_req;
  logic other_req;

  // two cores, so the other one is just the flipped index
  assign other = ~owner;
  assign own_req = mem_bus_pkg::req_any(req[owner]);
  assign other_req = mem_bus_pkg::req_any(req[other]);

  always_comb begin
    next_owner = owner;
    // hand over only when the owner is quiet and the other core waits
    if (switch_ok && !own_req && other_req) begin
      next_owner = other;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      // core 0 owns the bus out of reset
      owner <= '0;
    end else begin
      owner <= next_owner;
    end
  end

  // ownership is frozen while a transaction runs
  owner_held: assert property (
    @(posedge CLK) disable iff (!nRST)
    !switch_ok |=> $stable(owner)
  ) else $error("bus owner changed without switch_ok");

endmodule

// ==== rtl/coherence_fsm.sv ====
`timescale 1ns/100ps

module coherence_fsm (
  input  logic                                            CLK,
  input  logic                                            nRST,
  input  mem_bus_pkg::cache_req_t [mem_bus_pkg::CORES-1:0] req,
  input  mem_bus_pkg::core_id_t                           owner,
  input  mem_bus_pkg::ram_rsp_t                           ram_rsp,
  output logic                                            switch_ok,
  output mem_bus_pkg::bus_ctrl_t                          ctrl
);

  mem_bus_pkg::mc_state_t state;
  mem_bus_pkg::mc_state_t next_state;
  mem_bus_pkg::cache_req_t own_req;
  mem_bus_pkg::core_id_t peer;
  logic ram_access;
  logic peer_dirty;

  assign peer = ~owner;
  assign own_req = req[owner];
  // peer flags a dirty copy of the snooped line
  assign peer_dirty = req[peer].ccwrite;
  assign ram_access = (ram_rsp.state == mem_bus_pkg::ACCESS);

  // arbiter may only move while nothing starts
  assign switch_ok = (state == mem_bus_pkg::IDLE) && !mem_bus_pkg::req_any(own_req);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= mem_bus_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // next state
  always_comb begin
    next_state = state;
    unique case (state)
      mem_bus_pkg::IDLE: begin
        // data read miss first
        if (own_req.dren && !own_req.ccwrite) begin
          next_state = mem_bus_pkg::PRRD;
        end else if (own_req.dwen && !own_req.ccwrite) begin
          // plain eviction to ram
          next_state = mem_bus_pkg::CACWB;
        end else if (own_req.ccwrite) begin
          // write miss, needs the line exclusive
          next_state = mem_bus_pkg::PRWR;
        end else if (own_req.iren) begin
          next_state = mem_bus_pkg::IMEM;
        end
      end
      // single word transfers
      mem_bus_pkg::IMEM,
      mem_bus_pkg::CACWB: begin
        if (ram_access) begin
          next_state = mem_bus_pkg::IDLE;
        end
      end
      // snoop cycle picks ram or peer as the source
      mem_bus_pkg::PRRD: begin
        next_state = peer_dirty ? mem_bus_pkg::BUSWB1 : mem_bus_pkg::BUSRD1;
      end
      mem_bus_pkg::PRWR: begin
        next_state = peer_dirty ? mem_bus_pkg::BUSWBX1 : mem_bus_pkg::BUSRDX1;
      end
      // ram sourced words wait for access
      mem_bus_pkg::BUSRD1: begin
        if (ram_access) begin
          next_state = mem_bus_pkg::BUSRD2;
        end
      end
      mem_bus_pkg::BUSWB1: begin
        if (ram_access) begin
          next_state = mem_bus_pkg::BUSWB2;
        end
      end
      mem_bus_pkg::BUSRDX1: begin
        if (ram_access) begin
          next_state = mem_bus_pkg::BUSRDX2;
        end
      end
      mem_bus_pkg::BUSRD2,
      mem_bus_pkg::BUSWB2,
      mem_bus_pkg::BUSRDX2: begin
        if (ram_access) begin
          next_state = mem_bus_pkg::IDLE;
        end
      end
      // peer words skip ram, one cycle each
      mem_bus_pkg::BUSWBX1: next_state = mem_bus_pkg::BUSWBX2;
      mem_bus_pkg::BUSWBX2: next_state = mem_bus_pkg::IDLE;
      default: next_state = mem_bus_pkg::IDLE;
    endcase
  end

  // per-state route, word completion and coherence strobes
  always_comb begin
    ctrl = '0;
    ctrl.route = mem_bus_pkg::R_NONE;
    unique case (state)
      mem_bus_pkg::IMEM: begin
        ctrl.route = mem_bus_pkg::R_RAM_I;
        ctrl.word_done = ram_access;
      end
      mem_bus_pkg::CACWB: begin
        ctrl.route = mem_bus_pkg::R_D_RAM;
        ctrl.word_done = ram_access;
      end
      // snoop only, no data moves yet
      mem_bus_pkg::PRRD,
      mem_bus_pkg::PRWR: begin
        ctrl.snoop = 1'b1;
      end
      mem_bus_pkg::BUSRD1,
      mem_bus_pkg::BUSRD2,
      mem_bus_pkg::BUSRDX1: begin
        ctrl.route = mem_bus_pkg::R_RAM_D;
        ctrl.word_done = ram_access;
      end
      mem_bus_pkg::BUSRDX2: begin
        ctrl.route = mem_bus_pkg::R_RAM_D;
        ctrl.word_done = ram_access;
        // kill the peer copy once the line is ours
        ctrl.invalidate = ram_access;
      end
      // dirty peer data also lands in ram
      mem_bus_pkg::BUSWB1,
      mem_bus_pkg::BUSWB2: begin
        ctrl.route = mem_bus_pkg::R_PEER_D_RAM;
        ctrl.word_done = ram_access;
        ctrl.snoop = 1'b1;
      end
      mem_bus_pkg::BUSWBX1: begin
        ctrl.route = mem_bus_pkg::R_PEER_D;
        ctrl.word_done = 1'b1;
        ctrl.snoop = 1'b1;
      end
      mem_bus_pkg::BUSWBX2: begin
        ctrl.route = mem_bus_pkg::R_PEER_D;
        ctrl.word_done = 1'b1;
        ctrl.snoop = 1'b1;
        ctrl.invalidate = 1'b1;
      end
      default: ctrl.route = mem_bus_pkg::R_NONE;
    endcase
  end

  // invalidate only in the last exclusive word of an owner asking for the line
  inv_pulse: assert property (
    @(posedge CLK) disable iff (!nRST)
    ctrl.invalidate |->
      own_req.ccwrite && (state inside {mem_bus_pkg::BUSRDX2, mem_bus_pkg::BUSWBX2})
  ) else $error("invalidate outside the second exclusive word");

  // idle owner with no request keeps the bus idle
  idle_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (state == mem_bus_pkg::IDLE) && !mem_bus_pkg::req_any(own_req)
      |=> state == mem_bus_pkg::IDLE
  ) else $error("transaction started without an owner request");

endmodule

// ==== rtl/bus_data_router.sv ====
`timescale 1ns/100ps

module bus_data_router (
  input  mem_bus_pkg::cache_req_t [mem_bus_pkg::CORES-1:0] req,
  input  mem_bus_pkg::core_id_t                           owner,
  input  mem_bus_pkg::bus_ctrl_t                          ctrl,
  input  mem_bus_pkg::ram_rsp_t                           ram_rsp,
  output mem_bus_pkg::ram_req_t                           ram_req,
  output mem_bus_pkg::cache_rsp_t [mem_bus_pkg::CORES-1:0] rsp
);

  mem_bus_pkg::core_id_t peer;
  mem_bus_pkg::word_t ram_data;
  mem_bus_pkg::word_t peer_data;

  assign peer = ~owner;
  // ram load only counts in the access cycle
  assign ram_data = (ram_rsp.state == mem_bus_pkg::ACCESS) ? ram_rsp.load : '0;
  assign peer_data = req[peer].dstore;

  always_comb begin
    ram_req = '0;
    // both caches stall by default
    for (int c = 0; c < mem_bus_pkg::CORES; c++) begin
      rsp[c] = '0;
      rsp[c].iwait = 1'b1;
      rsp[c].dwait = 1'b1;
    end

    unique case (ctrl.route)
      // instruction fetch from ram
      mem_bus_pkg::R_RAM_I: begin
        ram_req.ren = 1'b1;
        ram_req.addr = req[owner].iaddr;
        rsp[owner].iload = ram_data;
        rsp[owner].iwait = !ctrl.word_done;
      end
      // coherent read with a clean or absent peer copy
      mem_bus_pkg::R_RAM_D: begin
        ram_req.ren = 1'b1;
        ram_req.addr = req[owner].daddr;
        rsp[owner].dload = ram_data;
        rsp[owner].dwait = !ctrl.word_done;
      end
      // peer supplies the word and ram takes a copy
      mem_bus_pkg::R_PEER_D_RAM: begin
        ram_req.wen = 1'b1;
        ram_req.addr = req[owner].daddr;
        ram_req.store = peer_data;
        rsp[owner].dload = peer_data;
        rsp[owner].dwait = !ctrl.word_done;
      end
      // cache to cache, ram untouched
      mem_bus_pkg::R_PEER_D: begin
        rsp[owner].dload = peer_data;
        rsp[owner].dwait = !ctrl.word_done;
      end
      // owner eviction
      mem_bus_pkg::R_D_RAM: begin
        ram_req.wen = 1'b1;
        ram_req.addr = req[owner].daddr;
        ram_req.store = req[owner].dstore;
        rsp[owner].dwait = !ctrl.word_done;
      end
      default: ram_req = '0;
    endcase

    // snoop side, always aimed at the peer
    rsp[peer].ccwait = ctrl.snoop;
    if (ctrl.snoop) begin
      rsp[peer].ccsnoopaddr = req[owner].daddr;
    end
    rsp[peer].ccinv = ctrl.invalidate;
  end

endmodule

// ==== rtl/ram_model.sv ====
`timescale 1ns/100ps

module ram_model (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mem_bus_pkg::ram_req_t ram_req,
  output mem_bus_pkg::ram_rsp_t ram_rsp
);

  mem_bus_pkg::word_t mem [mem_bus_pkg::RAM_WORDS];
  mem_bus_pkg::row_t row;
  mem_bus_pkg::addr_t last_addr;
  mem_bus_pkg::lat_cnt_t cnt;
  mem_bus_pkg::lat_cnt_t cur_cnt;
  logic active;
  logic done;

  // word index above the byte offset
  assign row = ram_req.addr[mem_bus_pkg::ROW_W+1:2];
  assign active = ram_req.ren | ram_req.wen;
  // new address restarts the busy period
  assign cur_cnt = (ram_req.addr == last_addr) ? cnt : '0;
  assign done = active && (cur_cnt == mem_bus_pkg::lat_cnt_t'(mem_bus_pkg::RAM_LAT));

  always_comb begin
    ram_rsp.load = mem[row];
    if (!active) begin
      ram_rsp.state = mem_bus_pkg::FREE;
    end else if (done) begin
      ram_rsp.state = mem_bus_pkg::ACCESS;
    end else begin
      ram_rsp.state = mem_bus_pkg::BUSY;
    end
  end

  // latency counter, cleared after every access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (active && !done) begin
      cnt <= cur_cnt + 1'b1;
    end else begin
      cnt <= '0;
    end
  end

  // address seen last cycle
  always_ff @(posedge CLK) begin
    last_addr <= ram_req.addr;
  end

  // write lands in the access cycle
  always_ff @(posedge CLK) begin
    if (ram_req.wen && done) begin
      mem[row] <= ram_req.store;
    end
  end

  rw_exclusive: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(ram_req.ren && ram_req.wen)
  ) else $error("ram read and write enabled together");

endmodule

// ==== rtl/memory_subsystem.sv ====
`timescale 1ns/100ps

module memory_subsystem (
  input  logic                                             CLK,
  input  logic                                             nRST,
  input  mem_bus_pkg::cache_req_t [mem_bus_pkg::CORES-1:0]  req,
  output mem_bus_pkg::cache_rsp_t [mem_bus_pkg::CORES-1:0]  rsp
);

  // bus ownership
  mem_bus_pkg::core_id_t owner;
  logic switch_ok;

  // controller to router
  mem_bus_pkg::bus_ctrl_t ctrl;

  // shared ram port
  mem_bus_pkg::ram_req_t ram_req;
  mem_bus_pkg::ram_rsp_t ram_rsp;

  core_arbiter u_arbiter (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .switch_ok (switch_ok),
    .owner     (owner)
  );

  coherence_fsm u_fsm (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .owner     (owner),
    .ram_rsp   (ram_rsp),
    .switch_ok (switch_ok),
    .ctrl      (ctrl)
  );

  // combinational steering between ram and both caches
  bus_data_router u_router (
    .req     (req),
    .owner   (owner),
    .ctrl    (ctrl),
    .ram_rsp (ram_rsp),
    .ram_req (ram_req),
    .rsp     (rsp)
  );

  ram_model u_ram (
    .CLK     (CLK),
    .nRST    (nRST),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

endmodule

// ==== verif/tb_memory_subsystem.sv ====
`timescale 1ns/100ps

module tb_memory_subsystem;

  localparam int WAIT_LIMIT = 40;

  logic CLK;
  logic nRST;
  mem_bus_pkg::cache_req_t [1:0] req;
  mem_bus_pkg::cache_rsp_t [1:0] rsp;

  // expected ram contents, indexed by word row
  mem_bus_pkg::word_t shadow [256];
  mem_bus_pkg::word_t exp_d [2];
  mem_bus_pkg::word_t exp_i [2];
  // word address a coherent read is asking for
  mem_bus_pkg::addr_t line_addr [2];
  logic [1:0] chk_d;
  logic [1:0] chk_i;
  // coherent read sourced by a dirty peer
  logic [1:0] peer_src;
  // agent is on the final word of its transaction
  logic [1:0] last_word;
  logic [1:0] rdx_last;
  logic [1:0] pending;
  logic [1:0] xend;
  logic [2:0] skips [2];
  logic [1:0] prev_end;
  logic started;
  logic alt_mode;

  memory_subsystem dut0 (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .rsp  (rsp)
  );

  always #5 CLK = ~CLK;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // quiet bus until the first request
  reset_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    !started |-> rsp[0].iwait && rsp[0].dwait && rsp[1].iwait && rsp[1].dwait &&
      !rsp[0].ccinv && !rsp[1].ccinv && !rsp[0].ccwait && !rsp[1].ccwait)
    else stop_run($sformatf("ERROR %0t: bus not quiet before the first request", $time));

  for (genvar c = 0; c < 2; c++) begin : g_core
    assign pending[c] = req[c].iren | req[c].dren | req[c].dwen | req[c].ccwrite;
    // transaction ends when the last word completes
    assign xend[c] = last_word[c] && (!rsp[c].iwait || !rsp[c].dwait);

    always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
        skips[c] <= '0;
      end else if (xend[c] || !pending[c]) begin
        skips[c] <= '0;
      end else if (xend[1-c]) begin
        skips[c] <= skips[c] + 3'd1;
      end
    end

    dload_ok: assert property (@(posedge CLK) disable iff (!nRST)
      chk_d[c] && !rsp[c].dwait |-> rsp[c].dload == exp_d[c])
      else stop_run($sformatf("ERROR %0t: core %0d dload %h, expected %h",
        $time, c, $sampled(rsp[c].dload), exp_d[c]));

    iload_ok: assert property (@(posedge CLK) disable iff (!nRST)
      chk_i[c] && !rsp[c].iwait |-> rsp[c].iload == exp_i[c])
      else stop_run($sformatf("ERROR %0t: core %0d iload %h, expected %h",
        $time, c, $sampled(rsp[c].iload), exp_i[c]));

    // snoop only during the other core's coherent read, aimed at its word
    snoop_addr_ok: assert property (@(posedge CLK) disable iff (!nRST)
      rsp[c].ccwait |-> chk_d[1-c] && rsp[c].ccsnoopaddr == line_addr[1-c])
      else stop_run($sformatf("ERROR %0t: core %0d ccwait with snoop address %h, expected %h",
        $time, c, $sampled(rsp[c].ccsnoopaddr), line_addr[1-c]));

    // peer stays held while it sources the word
    snoop_held: assert property (@(posedge CLK) disable iff (!nRST)
      peer_src[c] && !rsp[c].dwait |-> rsp[1-c].ccwait)
      else stop_run($sformatf("ERROR %0t: ccwait low while core %0d takes peer data",
        $time, c));

    // ccinv only with the peer's last exclusive word
    inv_place: assert property (@(posedge CLK) disable iff (!nRST)
      rsp[c].ccinv |-> rdx_last[1-c] && !rsp[1-c].dwait)
      else stop_run($sformatf("ERROR %0t: stray ccinv to core %0d", $time, c));

    inv_present: assert property (@(posedge CLK) disable iff (!nRST)
      rdx_last[c] && !rsp[c].dwait |-> rsp[1-c].ccinv)
      else stop_run($sformatf("ERROR %0t: no ccinv for exclusive read by core %0d",
        $time, c));

    alternate: assert property (@(posedge CLK) disable iff (!nRST)
      alt_mode && xend[c] |-> prev_end != 2'(c))
      else stop_run($sformatf("ERROR %0t: core %0d finished twice in a row", $time, c));

    no_starve: assert property (@(posedge CLK) disable iff (!nRST)
      skips[c] <= 3'd2)
      else stop_run($sformatf("ERROR %0t: core %0d starved", $time, c));
  end

  // last core to finish, only tracked under contention
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      prev_end <= 2'd2;
    end else if (!alt_mode) begin
      prev_end <= 2'd2;
    end else if (xend[0]) begin
      prev_end <= 2'd0;
    end else if (xend[1]) begin
      prev_end <= 2'd1;
    end
  end

  // polls at negedge, wait low there finishes the word
  task automatic finish_word(input mem_bus_pkg::core_id_t c, input logic instr);
    int n;
    n = 0;
    @(negedge CLK);
    while ((instr ? rsp[c].iwait : rsp[c].dwait) && n < WAIT_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (instr ? rsp[c].iwait : rsp[c].dwait) begin
      stop_run($sformatf("timeout: core %0d %s never dropped", c,
        instr ? "iwait" : "dwait"));
    end
  endtask

  task automatic write_back(input mem_bus_pkg::core_id_t c, input mem_bus_pkg::addr_t a,
                            input mem_bus_pkg::word_t d);
    @(posedge CLK);
    #1;
    started = 1'b1;
    req[c].dwen = 1'b1;
    req[c].daddr = a;
    req[c].dstore = d;
    last_word[c] = 1'b1;
    finish_word(c, 1'b0);
    shadow[a[9:2]] = d;
    @(posedge CLK);
    #1;
    req[c].dwen = 1'b0;
    last_word[c] = 1'b0;
  endtask

  task automatic fetch(input mem_bus_pkg::core_id_t c, input mem_bus_pkg::addr_t a);
    @(posedge CLK);
    #1;
    started = 1'b1;
    req[c].iren = 1'b1;
    req[c].iaddr = a;
    exp_i[c] = shadow[a[9:2]];
    chk_i[c] = 1'b1;
    last_word[c] = 1'b1;
    finish_word(c, 1'b1);
    @(posedge CLK);
    #1;
    req[c].iren = 1'b0;
    chk_i[c] = 1'b0;
    last_word[c] = 1'b0;
  endtask

  // two word coherent read, excl picks read-exclusive
  task automatic line_read(input mem_bus_pkg::core_id_t c, input mem_bus_pkg::addr_t base,
                           input logic dirty, input logic excl);
    mem_bus_pkg::core_id_t p;
    mem_bus_pkg::addr_t a;
    mem_bus_pkg::word_t tag;
    p = ~c;
    tag = $urandom;
    @(posedge CLK);
    #1;
    started = 1'b1;
    req[c].dren = !excl;
    req[c].ccwrite = excl;
    peer_src[c] = dirty;
    for (int w = 0; w < 2; w++) begin
      a = base + mem_bus_pkg::addr_t'(4 * w);
      req[c].daddr = a;
      line_addr[c] = a;
      // dirty peer line data tied to its address
      req[p].dstore = tag ^ a;
      exp_d[c] = dirty ? (tag ^ a) : shadow[a[9:2]];
      chk_d[c] = 1'b1;
      last_word[c] = (w == 1);
      rdx_last[c] = excl && (w == 1);
      if (w == 0) begin
        // peer flags dirty once the requester holds the bus
        @(posedge CLK);
        #1;
        req[p].ccwrite = dirty;
      end
      finish_word(c, 1'b0);
      if (dirty && !excl) begin
        shadow[a[9:2]] = tag ^ a;
      end
      @(posedge CLK);
      #1;
    end
    req[c].dren = 1'b0;
    req[c].ccwrite = 1'b0;
    req[p].ccwrite = 1'b0;
    chk_d[c] = 1'b0;
    peer_src[c] = 1'b0;
    last_word[c] = 1'b0;
    rdx_last[c] = 1'b0;
  endtask

  // back to back traffic on a private region per core
  task automatic traffic(input mem_bus_pkg::core_id_t c);
    mem_bus_pkg::addr_t a;
    for (int k = 0; k < 3; k++) begin
      a = 32'h100 + (c ? 32'h40 : 32'h0) + mem_bus_pkg::addr_t'(4 * k);
      write_back(c, a, $urandom);
      fetch(c, a);
    end
  endtask

  initial begin
    void'($urandom(20));
    CLK = 1'b0;
    nRST = 1'b0;
    req = '0;
    chk_d = '0;
    chk_i = '0;
    peer_src = '0;
    last_word = '0;
    rdx_last = '0;
    started = 1'b0;
    alt_mode = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    // idle window for the reset check
    repeat (4) @(posedge CLK);
    // fill four lines from 0x40
    for (int i = 0; i < 8; i++) begin
      write_back(mem_bus_pkg::core_id_t'(i[0]), 32'h40 + mem_bus_pkg::addr_t'(4 * i),
        $urandom);
    end
    // write-back then read and fetch
    write_back(1'b1, 32'h5c, $urandom);
    fetch(1'b0, 32'h5c);
    line_read(1'b1, 32'h58, 1'b0, 1'b0);
    // dirty peer on plain read, then ram copy
    line_read(1'b0, 32'h40, 1'b1, 1'b0);
    line_read(1'b1, 32'h40, 1'b0, 1'b0);
    // read-exclusive, dirty peer leaves ram old
    line_read(1'b1, 32'h48, 1'b1, 1'b1);
    line_read(1'b0, 32'h48, 1'b0, 1'b0);
    line_read(1'b0, 32'h50, 1'b0, 1'b1);
    // both cores busy at once
    alt_mode = 1'b1;
    fork
      traffic(1'b0);
      traffic(1'b1);
    join
    alt_mode = 1'b0;
    repeat (2) @(posedge CLK);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/mem_bus_pkg.sv
rtl/core_arbiter.sv
rtl/coherence_fsm.sv
rtl/bus_data_router.sv
rtl/ram_model.sv
rtl/memory_subsystem.sv
verif/tb_memory_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_memory_subsystem
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
